/* bench/tb_u2_ctrl.sv */
////////////////////////////////////////////////////////////
// Testbench for the control plane: reads the operation table,
// acts as Wishbone master and drives the irq and status pins
////////////////////////////////////////////////////////////
module tb_u2_ctrl;
   timeunit 1ns;
   timeprecision 100ps;
   import u2_ctrl_pkg::*;

   localparam int NAME_W  = 8*24;
   localparam int MAX_OPS = 64;

   logic               dsp_clk;
   logic               rst_n_i;
   logic               wb_cyc_i;
   logic               wb_stb_i;
   logic               wb_we_i;
   logic [AW-1:0]      wb_adr_i;
   logic [SW-1:0]      wb_sel_i;
   logic [DW-1:0]      wb_dat_i;
   logic [DW-1:0]      wb_dat_o;
   logic               wb_ack_o;
   logic               wb_err_o;
   logic [NUM_IRQ-1:0] irq_i;
   logic [DW-1:0]      status_i;
   logic               sim_mode_i;
   logic [3:0]         clock_divider_i;
   logic               int_o;
   logic               clock_ready_o;
   logic [1:0]         clk_en_o;
   logic [1:0]         clk_sel_o;
   logic               ser_enable_o;
   logic               ser_prbsen_o;
   logic               ser_loopen_o;
   logic               ser_rx_en_o;
   logic               adc_oe_a_o;
   logic               adc_on_a_o;
   logic               adc_oe_b_o;
   logic               adc_on_b_o;
   logic [7:0]         leds_o;
   logic               phy_reset_n_o;
   logic               timeout;

   // Operation table from the data file
   logic [7:0]         op_code [MAX_OPS];
   logic [NAME_W-1:0]  op_name [MAX_OPS];
   logic [31:0]        op_addr [MAX_OPS];
   logic [31:0]        op_data [MAX_OPS];
   logic [31:0]        op_exp  [MAX_OPS];
   int                 n_ops = 0;
   int                 setup_errors = 0;
   int                 cycle_limit = 50;

   initial dsp_clk = 1'b0;
   always #2 dsp_clk = ~dsp_clk;

   u2_ctrl_top u2_ctrl_top_inst (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_sel_i(wb_sel_i), .wb_dat_i(wb_dat_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o), .wb_err_o(wb_err_o),
      .irq_i(irq_i), .status_i(status_i), .sim_mode_i(sim_mode_i),
      .clock_divider_i(clock_divider_i), .int_o(int_o),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .leds_o(leds_o), .phy_reset_n_o(phy_reset_n_o));

   wb_checker #(.NAME_W(NAME_W)) wb_checker_inst (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .wb_ack_i(wb_ack_o), .wb_err_i(wb_err_o), .wb_dat_i(wb_dat_o),
      .int_i(int_o), .clock_ready_i(clock_ready_o),
      .clk_en_i(clk_en_o), .clk_sel_i(clk_sel_o),
      .ser_enable_i(ser_enable_o), .ser_prbsen_i(ser_prbsen_o),
      .ser_loopen_i(ser_loopen_o), .ser_rx_en_i(ser_rx_en_o),
      .adc_oe_a_i(adc_oe_a_o), .adc_on_a_i(adc_on_a_o),
      .adc_oe_b_i(adc_oe_b_o), .adc_on_b_i(adc_on_b_o),
      .leds_i(leds_o), .phy_reset_n_i(phy_reset_n_o),
      .cycle_limit_i(cycle_limit), .timeout_o(timeout));

   // Readback, settings and PIC nibbles of the address map
   function automatic logic slave_mapped(input logic [AW-1:0] addr);
      logic [3:0] nib;
      nib = addr[AW-1:AW-4];
      return (nib == 4'h5) || (nib == 4'h7) || (nib == 4'h8);
   endfunction

   ////////////////////////////////////////////////////////////
   // Data file reader, '#' starts a comment line
   task automatic load_ops();
      int                fd;
      int                c;
      int                cnt;
      logic [NAME_W-1:0] nm;
      logic [31:0]       a;
      logic [31:0]       d;
      logic [31:0]       e;
      fd = $fopen("bench/u2_testdata.txt", "r");
      if (fd == 0) begin
         $display("Could not open the test data file");
         setup_errors++;
      end else begin
         c = $fgetc(fd);
         while (c != -1 && n_ops < MAX_OPS) begin
            if (c == "#") begin
               while (c != -1 && c != "\n") begin
                  c = $fgetc(fd);
               end
            end else if (c != " " && c != "\n" && c != "\t" && c != "\r") begin
               cnt = $fscanf(fd, "%s %h %h %h", nm, a, d, e);
               if (cnt == 4) begin
                  op_code[n_ops] = c[7:0];
                  op_name[n_ops] = nm;
                  op_addr[n_ops] = a;
                  op_data[n_ops] = d;
                  op_exp[n_ops]  = e;
                  n_ops++;
               end else begin
                  $display("Malformed line after %0d operations in the test data", n_ops);
                  setup_errors++;
               end
            end
            c = $fgetc(fd);
         end
         $fclose(fd);
      end
   endtask

   task automatic run_transfer(input int k);
      logic is_write;
      is_write = (op_code[k] == "W");
      @(negedge dsp_clk);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = is_write;
      wb_adr_i = op_addr[k][AW-1:0];
      wb_dat_i = is_write ? op_data[k] : '0;
      wb_checker_inst.await_response(op_name[k], !slave_mapped(op_addr[k][AW-1:0]),
                                     !is_write, op_exp[k]);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      // Setting pins follow one edge after the ack
      if (is_write) begin
         @(negedge dsp_clk);
         wb_checker_inst.compare_pins(op_name[k], op_exp[k]);
      end
   endtask

   task automatic run_op(input int k);
      case (op_code[k])
         "W", "R": run_transfer(k);
         "I": begin
            @(negedge dsp_clk);
            irq_i = op_data[k][NUM_IRQ-1:0];
            @(negedge dsp_clk);
            @(negedge dsp_clk);
            wb_checker_inst.compare_pins(op_name[k], op_exp[k]);
         end
         "S": begin
            @(negedge dsp_clk);
            status_i        = op_data[k];
            sim_mode_i      = op_addr[k][4];
            clock_divider_i = op_addr[k][3:0];
         end
         default: begin
            $display("Unknown opcode %c in the test data", op_code[k]);
            setup_errors++;
         end
      endcase
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   initial begin
      int k;
      rst_n_i         = 1'b0;
      wb_cyc_i        = 1'b0;
      wb_stb_i        = 1'b0;
      wb_we_i         = 1'b0;
      wb_adr_i        = '0;
      wb_sel_i        = '1;
      wb_dat_i        = '0;
      irq_i           = '0;
      status_i        = '0;
      sim_mode_i      = 1'b0;
      clock_divider_i = '0;
      load_ops();
      cycle_limit = 10 * n_ops + 50;
      repeat (3) @(posedge dsp_clk);
      @(negedge dsp_clk);
      rst_n_i = 1'b1;
      if (n_ops == 0) begin
         $display("No operations found in the test data file");
         setup_errors++;
      end
      for (k = 0; k < n_ops; k++) begin
         run_op(k);
      end
      @(negedge dsp_clk);
      wb_checker_inst.print_counts(setup_errors);
      if (setup_errors == 0 && wb_checker_inst.total_errors() == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      wait (timeout === 1'b1);
      $display("Run stopped at the cycle limit of %0d before all operations finished",
               cycle_limit);
      wb_checker_inst.print_counts(setup_errors);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

/* bench/u2_testdata.txt */
# op name addr data expect, fields after the name in hex
# W expect = pin word after the write, R expect = read data, I data = irq, S addr = {sim,div}
I reset_state 0000 00000000 00010000
S config_a 001a cafe0123 00000000
W clk_word 7000 00000015 00010015
W ser_word 7004 0000000a 00010a15
W adc_word 7008 00000006 00016a15
W led_word 700c 000000a5 a5016a15
W phy_reset 7010 00000001 a5006a15
W clk_wide 7000 ffffffe3 a5006a03
W unused_addr 7024 ffffffff a5006a03
W phy_release 7010 fffffffe a5016a03
R set_read 7000 00000000 00000000
R rb_config 5000 00000000 8000000a
R rb_status 5004 00000000 cafe0123
R rb_word7 501c 00000000 00000000
S config_b 0003 00005a5a 00000000
R rb_config_b 5000 00000000 00000003
R rb_status_b 5004 00000000 00005a5a
# PIC level mode on line 2
W pic_pol 8004 0000ffff a5016a03
W pic_clear_all 800c 0000ffff a5016a03
R pic_pend_idle 800c 00000000 00000000
R pic_mask_rst 8008 00000000 0000ffff
I lvl_irq_masked 0000 00000004 a5016a03
W lvl_unmask 8008 0000fffb a5116a03
R lvl_pend 800c 00000000 00000004
I lvl_irq_drop 0000 00000000 a5116a03
W lvl_clear 800c 00000004 a5016a03
R lvl_pend_clr 800c 00000000 00000000
# PIC edge mode on line 5, masked at first
W edge_mode 8000 00000020 a5016a03
R edge_mode_rb 8000 00000000 00000020
I edge_rise 0000 00000020 a5016a03
R edge_pend 800c 00000000 00000020
W edge_clear 800c 00000020 a5016a03
R edge_no_level 800c 00000000 00000000
I edge_fall 0000 00000000 a5016a03
I edge_rise2 0000 00000020 a5016a03
W edge_unmask 8008 0000ffdb a5116a03
W edge_ack 800c 00000020 a5016a03
# Unmapped slave, err expected
W bad_write 2000 00000001 a5016a03
R bad_read 2004 00000000 00000000

/* bench/wb_checker.sv */
////////////////////////////////////////////////////////////
// Response and pin checker for the control plane testbench;
// the top module calls its tasks once per operation
////////////////////////////////////////////////////////////
module wb_checker #(
   parameter int NAME_W     = 8*24,
   parameter int RESP_LIMIT = 16
) (
   input  logic                       dsp_clk,
   input  logic                       rst_n_i,
   input  logic                       wb_ack_i,
   input  logic                       wb_err_i,
   input  logic [u2_ctrl_pkg::DW-1:0] wb_dat_i,
   input  logic                       int_i,
   input  logic                       clock_ready_i,
   input  logic [1:0]                 clk_en_i,
   input  logic [1:0]                 clk_sel_i,
   input  logic                       ser_enable_i,
   input  logic                       ser_prbsen_i,
   input  logic                       ser_loopen_i,
   input  logic                       ser_rx_en_i,
   input  logic                       adc_oe_a_i,
   input  logic                       adc_on_a_i,
   input  logic                       adc_oe_b_i,
   input  logic                       adc_on_b_i,
   input  logic [7:0]                 leds_i,
   input  logic                       phy_reset_n_i,
   input  int                         cycle_limit_i,
   output logic                       timeout_o
);
   timeunit 1ns;
   timeprecision 100ps;

   int          check_count = 0;
   int          value_errors = 0;
   int          protocol_errors = 0;
   int          cycles;
   logic [31:0] pins;

   // Pin word, nibble aligned as in the data file
   assign pins = {leds_i, 3'b000, int_i, 3'b000, phy_reset_n_i,
                  adc_oe_a_i, adc_on_a_i, adc_oe_b_i, adc_on_b_i,
                  ser_enable_i, ser_prbsen_i, ser_loopen_i, ser_rx_en_i,
                  3'b000, clock_ready_i, clk_en_i, clk_sel_i};

   // Run length guard
   always @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cycles    <= 0;
         timeout_o <= 1'b0;
      end else begin
         cycles <= cycles + 1;
         if (cycles + 1 >= cycle_limit_i) begin
            timeout_o <= 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Wait for ack or err of the transfer now on the bus
   task automatic await_response(input logic [NAME_W-1:0] name, input logic exp_err,
                                 input logic chk_data, input logic [31:0] exp_data);
      int   waited;
      logic got;
      waited = 0;
      got    = 1'b0;
      while (!got && waited < RESP_LIMIT) begin
         @(negedge dsp_clk);
         waited++;
         if (wb_ack_i || wb_err_i) begin
            got = 1'b1;
         end
      end
      check_count++;
      if (!got) begin
         $display("Error in %0s: no ack or err within %0d cycles", name, RESP_LIMIT);
         protocol_errors++;
      end else if (waited != 1) begin
         $display("Error in %0s: response came %0d cycles after the request, not one",
                  name, waited);
         protocol_errors++;
      end else if (wb_ack_i && wb_err_i) begin
         $display("Error in %0s: ack and err were raised together", name);
         protocol_errors++;
      end else if (exp_err && !wb_err_i) begin
         $display("Error in %0s: unmapped address was acknowledged instead of err", name);
         protocol_errors++;
      end else if (!exp_err && wb_err_i) begin
         $display("Error in %0s: mapped address answered with err", name);
         protocol_errors++;
      end else if (!exp_err && chk_data && wb_dat_i !== exp_data) begin
         $display("Fail %0s: expected %08h, actual %08h", name, exp_data, wb_dat_i);
         value_errors++;
      end
   endtask

   task automatic compare_pins(input logic [NAME_W-1:0] name, input logic [31:0] exp_pins);
      check_count++;
      if (pins !== exp_pins) begin
         $display("Fail %0s: expected %08h, actual %08h", name, exp_pins, pins);
         value_errors++;
      end
   endtask

   function automatic int total_errors();
      return value_errors + protocol_errors;
   endfunction

   task automatic print_counts(input int setup_errors);
      $display("Checks: %0d, wrong values: %0d, bus errors: %0d, setup errors: %0d",
               check_count, value_errors, protocol_errors, setup_errors);
   endtask

endmodule

/* filelist.f */
verilog/u2_ctrl_pkg.sv
verilog/wb_slave_decode.sv
verilog/settings_bus.sv
verilog/setting_reg.sv
verilog/simple_pic.sv
verilog/readback_mux.sv
verilog/u2_ctrl_top.sv
bench/wb_checker.sv
bench/tb_u2_ctrl.sv

/* verilog/readback_mux.sv */
////////////////////////////////////////////////////////////
// Read-only Wishbone slave returning one of sixteen status
// words; unused words read as zero
////////////////////////////////////////////////////////////
module readback_mux (
   input  logic                       dsp_clk,
   input  logic                       rst_n_i,
   input  logic                       stb_i,
   input  logic [3:0]                 adr_i,
   output logic [u2_ctrl_pkg::DW-1:0] dat_o,
   output logic                       ack_o,
   input  logic [u2_ctrl_pkg::DW-1:0] config_word_i,
   input  logic [u2_ctrl_pkg::DW-1:0] status_i
);
   import u2_ctrl_pkg::*;

   logic access;

   assign access = stb_i & ~ack_o;

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= access;
      end
   end

   // Word select from address bits 5:2
   always_ff @(posedge dsp_clk) begin
      if (access) begin
         case (adr_i)
            RB_CONFIG: dat_o <= config_word_i;
            RB_STATUS: dat_o <= status_i;
            // Words 2 to 15 not populated
            default:   dat_o <= '0;
         endcase
      end
   end

endmodule

/* verilog/setting_reg.sv */
////////////////////////////////////////////////////////////
// Setting register at one address; keeps the low bits of
// the setting data that fit its payload type
////////////////////////////////////////////////////////////
module setting_reg #(
   parameter logic [u2_ctrl_pkg::SET_AW-1:0] MY_ADDR = '0,
   parameter type payload_t = logic
) (
   input  logic                           dsp_clk,
   input  logic                           rst_n_i,
   input  logic                           set_stb_i,
   input  logic [u2_ctrl_pkg::SET_AW-1:0] set_addr_i,
   input  logic [u2_ctrl_pkg::DW-1:0]     set_data_i,
   output payload_t                       out_o
);

   logic hit;

   assign hit = set_stb_i && (set_addr_i == MY_ADDR);

   // Payload fields map straight onto the low data bits
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_o <= '0;
      end else if (hit) begin
         out_o <= payload_t'(set_data_i[$bits(payload_t)-1:0]);
      end
   end

endmodule

/* verilog/settings_bus.sv */
////////////////////////////////////////////////////////////
// Write-only Wishbone slave; each write becomes a one-cycle
// setting strobe with an 8-bit address and 32-bit data
////////////////////////////////////////////////////////////
module settings_bus (
   input  logic                           dsp_clk,
   input  logic                           rst_n_i,
   input  logic                           stb_i,
   input  logic                           we_i,
   input  logic [u2_ctrl_pkg::DW-1:0]     dat_i,
   output logic                           ack_o,
   output logic                           set_stb_o,
   output logic [u2_ctrl_pkg::SET_AW-1:0] set_addr_o,
   output logic [u2_ctrl_pkg::DW-1:0]     set_data_o,
   input  logic [u2_ctrl_pkg::AW-1:0]     adr_i
);

   logic take;

   // New request, not yet acknowledged
   assign take = stb_i & ~ack_o;

   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o     <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         ack_o     <= take;
         set_stb_o <= take & we_i;
      end
   end

   // Word address bits 9:2 select the setting register
   always_ff @(posedge dsp_clk) begin
      if (take && we_i) begin
         set_addr_o <= adr_i[9:2];
         set_data_o <= dat_i;
      end
   end

endmodule

/* verilog/simple_pic.sv */
////////////////////////////////////////////////////////////
// Interrupt controller with per-line edge/level mode,
// polarity, mask and write-one-to-clear pending bits
////////////////////////////////////////////////////////////
module simple_pic (
   input  logic                            dsp_clk,
   input  logic                            rst_n_i,
   input  logic                            stb_i,
   input  logic                            we_i,
   input  logic [1:0]                      adr_i,
   input  logic [u2_ctrl_pkg::DW-1:0]      dat_i,
   input  logic [u2_ctrl_pkg::NUM_IRQ-1:0] irq_i,
   output logic [u2_ctrl_pkg::DW-1:0]      dat_o,
   output logic                            ack_o,
   output logic                            int_o
);
   import u2_ctrl_pkg::*;

   logic [NUM_IRQ-1:0] edge_en;
   logic [NUM_IRQ-1:0] pol;
   logic [NUM_IRQ-1:0] mask;
   logic [NUM_IRQ-1:0] pend;
   logic [NUM_IRQ-1:0] active;
   logic [NUM_IRQ-1:0] active_d;
   logic [NUM_IRQ-1:0] set_bits;
   logic [NUM_IRQ-1:0] clr_bits;
   logic               access;
   logic               wr;

   assign access = stb_i & ~ack_o;
   assign wr     = access & we_i;

   // Line is active when it equals its polarity bit
   assign active = ~(irq_i ^ pol);

   // Edge mode takes only the inactive-to-active transition
   assign set_bits = (edge_en & active & ~active_d) | (~edge_en & active);
   assign clr_bits = (wr && adr_i == PIC_PEND) ? dat_i[NUM_IRQ-1:0] : '0;

   ////////////////////////////////////////////////////////////
   // Control registers and pending
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o    <= 1'b0;
         edge_en  <= '0;
         pol      <= '0;
         mask     <= '1;
         pend     <= '0;
         active_d <= '0;
      end else begin
         ack_o    <= access;
         active_d <= active;
         // A new event wins over a clear in the same cycle
         pend     <= (pend & ~clr_bits) | set_bits;
         if (wr) begin
            case (adr_i)
               PIC_EDGE: edge_en <= dat_i[NUM_IRQ-1:0];
               PIC_POL:  pol     <= dat_i[NUM_IRQ-1:0];
               PIC_MASK: mask    <= dat_i[NUM_IRQ-1:0];
               default:  ;
            endcase
         end
      end
   end

   // Read data, valid with ack
   always_ff @(posedge dsp_clk) begin
      if (access) begin
         case (adr_i)
            PIC_EDGE: dat_o <= {{(DW-NUM_IRQ){1'b0}}, edge_en};
            PIC_POL:  dat_o <= {{(DW-NUM_IRQ){1'b0}}, pol};
            PIC_MASK: dat_o <= {{(DW-NUM_IRQ){1'b0}}, mask};
            default:  dat_o <= {{(DW-NUM_IRQ){1'b0}}, pend};
         endcase
      end
   end

   assign int_o = |(pend & ~mask);

endmodule

/* verilog/u2_ctrl_pkg.sv */
////////////////////////////////////////////////////////////
// Widths, address map and setting payload types shared by
// the control plane blocks of the radio core
////////////////////////////////////////////////////////////
package u2_ctrl_pkg;

   // Bus widths
   localparam int DW      = 32;
   localparam int AW      = 16;
   localparam int SW      = 4;
   localparam int SET_AW  = 8;
   localparam int NUM_IRQ = 16;

   // Slave map, matched against address bits 15:12
   localparam logic [3:0] SLV_READBACK = 4'd5;
   localparam logic [3:0] SLV_SETTINGS = 4'd7;
   localparam logic [3:0] SLV_PIC      = 4'd8;

   // Strobe and ack bit of each slave at the decoder
   localparam int IDX_READBACK = 0;
   localparam int IDX_SETTINGS = 1;
   localparam int IDX_PIC      = 2;

   // Setting register addresses
   localparam logic [SET_AW-1:0] SR_CLK = 8'd0;
   localparam logic [SET_AW-1:0] SR_SER = 8'd1;
   localparam logic [SET_AW-1:0] SR_ADC = 8'd2;
   localparam logic [SET_AW-1:0] SR_LED = 8'd3;
   localparam logic [SET_AW-1:0] SR_PHY = 8'd4;

   // Interrupt controller word offsets, address bits 3:2
   localparam logic [1:0] PIC_EDGE = 2'd0;
   localparam logic [1:0] PIC_POL  = 2'd1;
   localparam logic [1:0] PIC_MASK = 2'd2;
   localparam logic [1:0] PIC_PEND = 2'd3;

   // Readback words, address bits 5:2
   localparam logic [3:0] RB_CONFIG = 4'd0;
   localparam logic [3:0] RB_STATUS = 4'd1;

   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clk_ctrl_t;

   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } ser_ctrl_t;

   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef logic [7:0] led_t;

endpackage

/* verilog/u2_ctrl_top.sv */
////////////////////////////////////////////////////////////
// Control plane of the radio core: Wishbone decoder, status
// readback, settings bus with its registers, and the PIC
////////////////////////////////////////////////////////////
module u2_ctrl_top (
   input  logic                            dsp_clk,
   input  logic                            rst_n_i,
   // Wishbone from the external master
   input  logic                            wb_cyc_i,
   input  logic                            wb_stb_i,
   input  logic                            wb_we_i,
   input  logic [u2_ctrl_pkg::AW-1:0]      wb_adr_i,
   input  logic [u2_ctrl_pkg::SW-1:0]      wb_sel_i,
   input  logic [u2_ctrl_pkg::DW-1:0]      wb_dat_i,
   output logic [u2_ctrl_pkg::DW-1:0]      wb_dat_o,
   output logic                            wb_ack_o,
   output logic                            wb_err_o,
   // Status and interrupts
   input  logic [u2_ctrl_pkg::NUM_IRQ-1:0] irq_i,
   input  logic [u2_ctrl_pkg::DW-1:0]      status_i,
   input  logic                            sim_mode_i,
   input  logic [3:0]                      clock_divider_i,
   output logic                            int_o,
   // Clock generator
   output logic                            clock_ready_o,
   output logic [1:0]                      clk_en_o,
   output logic [1:0]                      clk_sel_o,
   // SERDES control
   output logic                            ser_enable_o,
   output logic                            ser_prbsen_o,
   output logic                            ser_loopen_o,
   output logic                            ser_rx_en_o,
   // ADC enables
   output logic                            adc_oe_a_o,
   output logic                            adc_on_a_o,
   output logic                            adc_oe_b_o,
   output logic                            adc_on_b_o,
   // Misc
   output logic [7:0]                      leds_o,
   output logic                            phy_reset_n_o
);
   import u2_ctrl_pkg::*;

   logic [2:0]        slv_stb;
   logic [2:0]        slv_ack;
   logic [DW-1:0]     rb_dat;
   logic [DW-1:0]     pic_dat;
   logic [DW-1:0]     config_word;
   logic              wr_en;
   logic              set_stb;
   logic [SET_AW-1:0] set_addr;
   logic [DW-1:0]     set_data;
   clk_ctrl_t         clk_ctrl;
   ser_ctrl_t         ser_ctrl;
   adc_ctrl_t         adc_ctrl;
   logic              phy_reset;

   // A write with no byte lane selected is taken as a read
   assign wr_en = wb_we_i & (|wb_sel_i);

   assign config_word = {sim_mode_i, {(DW-5){1'b0}}, clock_divider_i};

   wb_slave_decode wb_slave_decode_inst (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .cyc_i(wb_cyc_i), .stb_i(wb_stb_i), .adr_i(wb_adr_i),
      .stb_o(slv_stb), .ack_i(slv_ack),
      .rb_dat_i(rb_dat), .set_dat_i('0), .pic_dat_i(pic_dat),
      .dat_o(wb_dat_o), .ack_o(wb_ack_o), .err_o(wb_err_o));

   readback_mux readback_mux_inst (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .stb_i(slv_stb[IDX_READBACK]), .adr_i(wb_adr_i[5:2]),
      .dat_o(rb_dat), .ack_o(slv_ack[IDX_READBACK]),
      .config_word_i(config_word), .status_i(status_i));

   settings_bus settings_bus_inst (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .stb_i(slv_stb[IDX_SETTINGS]), .we_i(wr_en), .dat_i(wb_dat_i),
      .ack_o(slv_ack[IDX_SETTINGS]), .set_stb_o(set_stb),
      .set_addr_o(set_addr), .set_data_o(set_data), .adr_i(wb_adr_i));

   simple_pic simple_pic_inst (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i),
      .stb_i(slv_stb[IDX_PIC]), .we_i(wr_en), .adr_i(wb_adr_i[3:2]),
      .dat_i(wb_dat_i), .irq_i(irq_i),
      .dat_o(pic_dat), .ack_o(slv_ack[IDX_PIC]), .int_o(int_o));

   ////////////////////////////////////////////////////////////
   // Setting registers
   setting_reg #(.MY_ADDR(SR_CLK), .payload_t(clk_ctrl_t)) sr_clk (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb),
      .set_addr_i(set_addr), .set_data_i(set_data), .out_o(clk_ctrl));

   setting_reg #(.MY_ADDR(SR_SER), .payload_t(ser_ctrl_t)) sr_ser (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb),
      .set_addr_i(set_addr), .set_data_i(set_data), .out_o(ser_ctrl));

   setting_reg #(.MY_ADDR(SR_ADC), .payload_t(adc_ctrl_t)) sr_adc (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb),
      .set_addr_i(set_addr), .set_data_i(set_data), .out_o(adc_ctrl));

   setting_reg #(.MY_ADDR(SR_LED), .payload_t(led_t)) sr_led (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb),
      .set_addr_i(set_addr), .set_data_i(set_data), .out_o(leds_o));

   setting_reg #(.MY_ADDR(SR_PHY), .payload_t(logic)) sr_phy (
      .dsp_clk(dsp_clk), .rst_n_i(rst_n_i), .set_stb_i(set_stb),
      .set_addr_i(set_addr), .set_data_i(set_data), .out_o(phy_reset));

   // Pin split
   assign clock_ready_o = clk_ctrl.clock_ready;
   assign clk_en_o      = clk_ctrl.clk_en;
   assign clk_sel_o     = clk_ctrl.clk_sel;

   assign ser_enable_o  = ser_ctrl.enable;
   assign ser_prbsen_o  = ser_ctrl.prbsen;
   assign ser_loopen_o  = ser_ctrl.loopen;
   assign ser_rx_en_o   = ser_ctrl.rx_en;

   assign adc_oe_a_o    = adc_ctrl.oe_a;
   assign adc_on_a_o    = adc_ctrl.on_a;
   assign adc_oe_b_o    = adc_ctrl.oe_b;
   assign adc_on_b_o    = adc_ctrl.on_b;

   // PHY held out of reset while the setting bit is clear
   assign phy_reset_n_o = ~phy_reset;

endmodule

/* verilog/wb_slave_decode.sv */
////////////////////////////////////////////////////////////
// Single-master Wishbone decoder: steers the strobe to one
// of three slaves and answers unmapped addresses with err
////////////////////////////////////////////////////////////
module wb_slave_decode (
   input  logic                       dsp_clk,
   input  logic                       rst_n_i,
   // Master side
   input  logic                       cyc_i,
   input  logic                       stb_i,
   input  logic [u2_ctrl_pkg::AW-1:0] adr_i,
   // Slave side, one bit per slave
   output logic [2:0]                 stb_o,
   input  logic [2:0]                 ack_i,
   input  logic [u2_ctrl_pkg::DW-1:0] rb_dat_i,
   input  logic [u2_ctrl_pkg::DW-1:0] set_dat_i,
   input  logic [u2_ctrl_pkg::DW-1:0] pic_dat_i,
   // Back to the master
   output logic [u2_ctrl_pkg::DW-1:0] dat_o,
   output logic                       ack_o,
   output logic                       err_o
);
   import u2_ctrl_pkg::*;

   logic       req;
   logic [2:0] hit;
   logic       err_r;

   assign req = cyc_i & stb_i;

   // Slave select from the top nibble
   always_comb begin
      hit = '0;
      case (adr_i[AW-1:AW-4])
         SLV_READBACK: hit[IDX_READBACK] = 1'b1;
         SLV_SETTINGS: hit[IDX_SETTINGS] = 1'b1;
         SLV_PIC:      hit[IDX_PIC]      = 1'b1;
         default:      hit = '0;
      endcase
   end

   assign stb_o = hit & {3{req}};

   // Only the addressed slave is heard
   always_comb begin
      case (1'b1)
         hit[IDX_READBACK]: dat_o = rb_dat_i;
         hit[IDX_SETTINGS]: dat_o = set_dat_i;
         hit[IDX_PIC]:      dat_o = pic_dat_i;
         default:           dat_o = '0;
      endcase
   end

   assign ack_o = |(ack_i & hit);

   ////////////////////////////////////////////////////////////
   // Unmapped access, same one-cycle timing as a slave ack
   always_ff @(posedge dsp_clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_r <= 1'b0;
      end else begin
         err_r <= req & ~(|hit) & ~err_r;
      end
   end

   assign err_o = err_r;

endmodule
